// ==== hdl/addr_router.sv ====
`timescale 1ns/10ps
`default_nettype none

module addr_router (
    input  logic           clock,
    input  logic           rst_n,
    bus_req_if.dst         q,
    bus_rsp_if.src         rsp,
    clint_if.host          clint,
    output logic           mem_req_valid,
    input  logic           mem_req_ready,
    output logic           mem_req_write,
    output bus_pkg::addr_t mem_req_addr,
    output bus_pkg::data_t mem_req_wdata,
    output bus_pkg::strb_t mem_req_wstrb,
    input  logic           mem_rsp_valid,
    input  bus_pkg::data_t mem_rsp_data,
    input  logic           mem_rsp_err
);
    import bus_pkg::*;

    route_state_e state;
    bus_req_t     held;                               // Request being served externally
    bus_rsp_t     rsp_q;
    logic         rsp_valid_q;
    logic         pop;
    logic         hit_clint;
    logic         ext_done;

    assign q.ready   = state == ROUTE_IDLE;           // One request at a time
    assign pop       = q.valid && q.ready;
    assign hit_clint = (q.req.addr & CLINT_MASK) == CLINT_BASE;
    assign ext_done  = state == ROUTE_EXT_WAIT && mem_rsp_valid;

    // CLINT access happens in the pop cycle itself
    assign clint.sel    = pop && hit_clint;
    assign clint.we     = q.req.op == OP_WRITE;
    assign clint.offset = q.req.addr[OFF_W-1:0];
    assign clint.wdata  = q.req.wdata;
    assign clint.wstrb  = q.req.wstrb;

    assign mem_req_valid = state == ROUTE_EXT_REQ;    // Rises the cycle after pop
    assign mem_req_write = held.op == OP_WRITE;
    assign mem_req_addr  = held.addr;
    assign mem_req_wdata = held.wdata;
    assign mem_req_wstrb = held.wstrb;

    assign rsp.valid = rsp_valid_q;
    assign rsp.rsp   = rsp_q;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state       <= ROUTE_IDLE;
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= clint.sel || ext_done;     // Single-cycle pulse
            case (state)
                ROUTE_IDLE: begin
                    if (pop) begin
                        state <= hit_clint ? ROUTE_CLINT : ROUTE_EXT_REQ;
                    end
                end
                ROUTE_CLINT:    state <= ROUTE_IDLE;  // Response goes out here
                ROUTE_EXT_REQ: begin
                    if (mem_req_ready) begin
                        state <= ROUTE_EXT_WAIT;
                    end
                end
                ROUTE_EXT_WAIT: begin
                    if (mem_rsp_valid) begin
                        state <= ROUTE_IDLE;
                    end
                end
                default:        state <= ROUTE_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (pop) begin
            held <= q.req;
        end
        if (clint.sel) begin
            rsp_q.src   <= q.req.src;
            rsp_q.rdata <= clint.we ? '0 : clint.rdata;  // Writes answer 0
            rsp_q.err   <= clint.err;
        end else if (ext_done) begin
            rsp_q.src   <= held.src;
            rsp_q.rdata <= (held.op == OP_WRITE) ? '0 : mem_rsp_data;
            rsp_q.err   <= mem_rsp_err;               // Passed straight through
        end
    end

endmodule

`default_nettype wire

// ==== hdl/bus_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module bus_arbiter (
    input  logic           clock,
    input  logic           rst_n,
    input  logic           fetch_req_valid,
    output logic           fetch_req_ready,
    input  bus_pkg::addr_t fetch_req_addr,
    output logic           fetch_rsp_valid,
    output bus_pkg::data_t fetch_rsp_data,
    output logic           fetch_rsp_err,
    input  logic           lsu_req_valid,
    output logic           lsu_req_ready,
    input  logic           lsu_req_write,
    input  bus_pkg::addr_t lsu_req_addr,
    input  bus_pkg::data_t lsu_req_wdata,
    input  bus_pkg::strb_t lsu_req_wstrb,
    output logic           lsu_rsp_valid,
    output bus_pkg::data_t lsu_rsp_data,
    output logic           lsu_rsp_err,
    bus_req_if.src         q,
    bus_rsp_if.dst         rsp
);
    import bus_pkg::*;

    src_e last_grant;                                 // Winner of the previous transfer
    logic fetch_busy;                                 // Fetch request in flight
    logic lsu_busy;
    logic fetch_elig;
    logic lsu_elig;
    logic pick_lsu;
    logic fetch_rsp_hit;
    logic lsu_rsp_hit;

    assign fetch_elig = fetch_req_valid && !fetch_busy;
    assign lsu_elig   = lsu_req_valid && !lsu_busy;
    assign pick_lsu   = lsu_elig && (!fetch_elig || last_grant == SRC_FETCH);  // Round robin

    assign q.valid         = fetch_elig || lsu_elig;
    assign fetch_req_ready = q.ready && fetch_elig && !pick_lsu;
    assign lsu_req_ready   = q.ready && pick_lsu;

    always_comb begin
        if (pick_lsu) begin
            q.req.src   = SRC_LSU;
            q.req.op    = lsu_req_write ? OP_WRITE : OP_READ;
            q.req.addr  = lsu_req_addr;
            q.req.wdata = lsu_req_wdata;
            q.req.wstrb = lsu_req_wstrb;
        end else begin
            q.req.src   = SRC_FETCH;
            q.req.op    = OP_READ;                    // Fetch only reads
            q.req.addr  = fetch_req_addr;
            q.req.wdata = '0;
            q.req.wstrb = '0;
        end
    end

    assign fetch_rsp_hit   = rsp.valid && rsp.rsp.src == SRC_FETCH;  // Demux by tag
    assign lsu_rsp_hit     = rsp.valid && rsp.rsp.src == SRC_LSU;
    assign fetch_rsp_valid = fetch_rsp_hit;
    assign fetch_rsp_data  = rsp.rsp.rdata;
    assign fetch_rsp_err   = rsp.rsp.err;
    assign lsu_rsp_valid   = lsu_rsp_hit;
    assign lsu_rsp_data    = rsp.rsp.rdata;
    assign lsu_rsp_err     = rsp.rsp.err;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            last_grant <= SRC_LSU;                    // Fetch wins the first tie
            fetch_busy <= 1'b0;
            lsu_busy   <= 1'b0;
        end else begin
            if (q.valid && q.ready) begin
                last_grant <= q.req.src;
            end
            if (fetch_req_valid && fetch_req_ready) begin
                fetch_busy <= 1'b1;
            end else if (fetch_rsp_hit) begin
                fetch_busy <= 1'b0;
            end
            if (lsu_req_valid && lsu_req_ready) begin
                lsu_busy <= 1'b1;
            end else if (lsu_rsp_hit) begin
                lsu_busy <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/bus_ifs.sv ====
`timescale 1ns/10ps
`default_nettype none

// Request channel, transfer on valid && ready
interface bus_req_if;
    logic              valid;
    logic              ready;
    bus_pkg::bus_req_t req;

    modport src (output valid, output req, input ready);
    modport dst (input valid, input req, output ready);
endinterface

// Response channel, one-cycle pulse, no back-pressure
interface bus_rsp_if;
    logic              valid;
    bus_pkg::bus_rsp_t rsp;

    modport src (output valid, output rsp);
    modport dst (input valid, input rsp);
endinterface

// Single-cycle register access into the CLINT
interface clint_if;
    logic                      sel;
    logic                      we;
    logic [bus_pkg::OFF_W-1:0] offset;
    bus_pkg::data_t            wdata;
    bus_pkg::strb_t            wstrb;
    bus_pkg::data_t            rdata;             // Combinational from offset
    logic                      err;               // Unknown offset

    modport host (
        output sel, output we, output offset, output wdata, output wstrb,
        input  rdata, input err
    );
    modport regs (
        input  sel, input we, input offset, input wdata, input wstrb,
        output rdata, output err
    );
endinterface

`default_nettype wire

// ==== hdl/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int STRB_W     = 4;                    // One strobe per byte lane
    localparam int OFF_W      = 16;                   // CLINT register offset bits
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

    localparam logic [ADDR_W-1:0] CLINT_BASE = 32'h0200_0000;
    localparam logic [ADDR_W-1:0] CLINT_MASK = 32'hFFFF_0000;  // 64 KiB window

    localparam logic [OFF_W-1:0] OFF_MSIP        = 16'h0000;
    localparam logic [OFF_W-1:0] OFF_MTIMECMP_LO = 16'h4000;
    localparam logic [OFF_W-1:0] OFF_MTIMECMP_HI = 16'h4004;
    localparam logic [OFF_W-1:0] OFF_MTIME_LO    = 16'hBFF8;
    localparam logic [OFF_W-1:0] OFF_MTIME_HI    = 16'hBFFC;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [STRB_W-1:0] strb_t;

    typedef enum logic {SRC_FETCH = 1'b0, SRC_LSU = 1'b1} src_e;
    typedef enum logic {OP_READ = 1'b0, OP_WRITE = 1'b1} bus_op_e;
    typedef enum logic [1:0] {
        ROUTE_IDLE     = 2'd0,
        ROUTE_CLINT    = 2'd1,                        // CLINT response cycle
        ROUTE_EXT_REQ  = 2'd2,                        // Waiting for mem_req_ready
        ROUTE_EXT_WAIT = 2'd3                         // Waiting for mem_rsp_valid
    } route_state_e;

    typedef struct packed {
        src_e    src;
        bus_op_e op;
        addr_t   addr;
        data_t   wdata;
        strb_t   wstrb;
    } bus_req_t;

    typedef struct packed {
        src_e  src;                                   // Requester that gets this response
        data_t rdata;
        logic  err;
    } bus_rsp_t;

endpackage

`default_nettype wire

// ==== hdl/clint_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

module clint_regs (
    input  logic  clock,
    input  logic  rst_n,
    clint_if.regs bus,
    output logic  timer_irq,
    output logic  soft_irq
);
    import bus_pkg::*;

    logic [63:0] mtime;                               // Free-running, +1 per clock
    logic [63:0] mtimecmp;
    logic        msip;
    logic        wr;

    // Byte-lane merge of a write into an existing word
    function automatic data_t merge_strb(input data_t old_w, input data_t new_w, input strb_t strb);
        data_t res;
        res = old_w;
        for (int i = 0; i < STRB_W; i++) begin
            if (strb[i]) begin
                res[i*8 +: 8] = new_w[i*8 +: 8];
            end
        end
        return res;
    endfunction

    assign wr = bus.sel && bus.we;

    always_comb begin
        bus.rdata = '0;                               // Unknown offset reads 0
        bus.err   = 1'b0;
        case (bus.offset)
            OFF_MSIP:        bus.rdata = {{(DATA_W-1){1'b0}}, msip};
            OFF_MTIMECMP_LO: bus.rdata = mtimecmp[31:0];
            OFF_MTIMECMP_HI: bus.rdata = mtimecmp[63:32];
            OFF_MTIME_LO:    bus.rdata = mtime[31:0];
            OFF_MTIME_HI:    bus.rdata = mtime[63:32];
            default:         bus.err   = 1'b1;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            mtime     <= '0;
            mtimecmp  <= '1;                          // No timer irq until programmed
            msip      <= 1'b0;
            timer_irq <= 1'b0;
            soft_irq  <= 1'b0;
        end else begin
            mtime     <= mtime + 64'd1;
            timer_irq <= mtime >= mtimecmp;
            soft_irq  <= msip;
            if (wr) begin
                case (bus.offset)                     // Later writes override the increment
                    OFF_MSIP: begin
                        if (bus.wstrb[0]) begin
                            msip <= bus.wdata[0];
                        end
                    end
                    OFF_MTIMECMP_LO: mtimecmp[31:0]  <= merge_strb(mtimecmp[31:0], bus.wdata, bus.wstrb);
                    OFF_MTIMECMP_HI: mtimecmp[63:32] <= merge_strb(mtimecmp[63:32], bus.wdata, bus.wstrb);
                    OFF_MTIME_LO:    mtime[31:0]     <= merge_strb(mtime[31:0], bus.wdata, bus.wstrb);
                    OFF_MTIME_HI:    mtime[63:32]    <= merge_strb(mtime[63:32], bus.wdata, bus.wstrb);
                    default: ;                        // Error response, no effect
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/cpu_bus_wrapper.sv ====
`timescale 1ns/10ps
`default_nettype none

// Fetch and LSU requesters, CLINT, external memory port
module cpu_bus_wrapper (
    input  logic           clock,
    input  logic           rst_n,
    input  logic           fetch_req_valid,
    output logic           fetch_req_ready,
    input  bus_pkg::addr_t fetch_req_addr,
    output logic           fetch_rsp_valid,
    output bus_pkg::data_t fetch_rsp_data,
    output logic           fetch_rsp_err,
    input  logic           lsu_req_valid,
    output logic           lsu_req_ready,
    input  logic           lsu_req_write,
    input  bus_pkg::addr_t lsu_req_addr,
    input  bus_pkg::data_t lsu_req_wdata,
    input  bus_pkg::strb_t lsu_req_wstrb,
    output logic           lsu_rsp_valid,
    output bus_pkg::data_t lsu_rsp_data,
    output logic           lsu_rsp_err,
    output logic           mem_req_valid,
    input  logic           mem_req_ready,
    output logic           mem_req_write,
    output bus_pkg::addr_t mem_req_addr,
    output bus_pkg::data_t mem_req_wdata,
    output bus_pkg::strb_t mem_req_wstrb,
    input  logic           mem_rsp_valid,
    input  bus_pkg::data_t mem_rsp_data,
    input  logic           mem_rsp_err,
    output logic           timer_irq,
    output logic           soft_irq
);

    bus_req_if arb_q ();                              // Arbiter to queue
    bus_req_if fifo_q ();                             // Queue to router
    bus_rsp_if rsp_bus ();                            // Router back to arbiter
    clint_if   clint_bus ();

    bus_arbiter bus_arbiter_u0 (
        .clock, .rst_n,
        .fetch_req_valid, .fetch_req_ready, .fetch_req_addr,
        .fetch_rsp_valid, .fetch_rsp_data, .fetch_rsp_err,
        .lsu_req_valid, .lsu_req_ready, .lsu_req_write,
        .lsu_req_addr, .lsu_req_wdata, .lsu_req_wstrb,
        .lsu_rsp_valid, .lsu_rsp_data, .lsu_rsp_err,
        .q   (arb_q.src),
        .rsp (rsp_bus.dst)
    );

    req_fifo req_fifo_u0 (
        .clock, .rst_n,
        .in  (arb_q.dst),
        .out (fifo_q.src)
    );

    addr_router addr_router_u0 (
        .clock, .rst_n,
        .q     (fifo_q.dst),
        .rsp   (rsp_bus.src),
        .clint (clint_bus.host),
        .mem_req_valid, .mem_req_ready, .mem_req_write,
        .mem_req_addr, .mem_req_wdata, .mem_req_wstrb,
        .mem_rsp_valid, .mem_rsp_data, .mem_rsp_err
    );

    clint_regs clint_regs_u0 (
        .clock, .rst_n,
        .bus (clint_bus.regs),
        .timer_irq,
        .soft_irq
    );

endmodule

`default_nettype wire

// ==== hdl/req_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module req_fifo (
    input  logic   clock,
    input  logic   rst_n,
    bus_req_if.dst in,
    bus_req_if.src out
);
    import bus_pkg::*;

    bus_req_t              mem [FIFO_DEPTH];          // Circular storage
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_PTR_W:0]   count;                     // One extra bit for full
    logic                  push;
    logic                  pop;

    assign in.ready  = count != (FIFO_PTR_W + 1)'(FIFO_DEPTH);  // Back-pressure when full
    assign out.valid = count != '0;
    assign out.req   = mem[rd_ptr];                   // Head of queue
    assign push      = in.valid && in.ready;
    assign pop       = out.valid && out.ready;

    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= in.req;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;              // Wraps, depth is a power of 2
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;              // Idle or both
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== project.f ====
hdl/bus_pkg.sv
hdl/bus_ifs.sv
hdl/bus_arbiter.sv
hdl/req_fifo.sv
hdl/addr_router.sv
hdl/clint_regs.sv
hdl/cpu_bus_wrapper.sv
tests/tb_cpu_bus_wrapper.sv

// ==== tests/bus_trace.txt ====
# name requester(F/L/B) op(R/W/M mtime/S msip/T mtimecmp hi) addr wdata wstrb exp_rdata exp_err
# B lines: fetch reads addr, load/store reads addr+4 and expects the wdata column
reset_mtime_hi     L R 0200BFFC 00000000 0 00000000 0
ext_write_full     L W 00001000 DEADBEEF F 00000000 0
ext_read_full      L R 00001000 00000000 0 DEADBEEF 0
ext_write_part     L W 00001000 11223344 5 00000000 0
ext_read_part      L R 00001000 00000000 0 DE22BE44 0
ext_read_init      L R 00002040 00000000 0 A5A585E5 0
ext_read_err       L R F0000000 00000000 0 00000000 1
ext_write_err      L W F0000010 12345678 F 00000000 1
fetch_read_init    F R 00000100 00000000 0 A5A5A4A5 0
fetch_read_written F R 00001000 00000000 0 DE22BE44 0
fetch_read_err     F R F0000100 00000000 0 00000000 1
msip_set           L S 02000000 00000001 1 00000000 0
msip_read          L R 02000000 00000000 0 00000001 0
msip_clear         L S 02000000 00000000 1 00000000 0
mtimecmp_lo        L W 02004000 00000040 F 00000000 0
mtimecmp_lo_read   L R 02004000 00000000 0 00000040 0
mtimecmp_hi        L T 02004004 00000000 F 00000000 0
mtime_lo_first     L M 0200BFF8 00000000 0 00000000 0
mtime_lo_second    L M 0200BFF8 00000000 0 00000000 0
clint_bad_offset   L R 02000010 00000000 0 00000000 1
fetch_mtime_lo     F M 0200BFF8 00000000 0 00000000 0
both_ext_init      B R 00003000 A5A595A1 0 A5A595A5 0
both_ext_written   B R 00000FFC DE22BE44 0 A5A5AA59 0

// ==== tests/tb_cpu_bus_wrapper.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_cpu_bus_wrapper;
    import bus_pkg::*;

    localparam int    HALF       = 4;                 // 8 ns clock
    localparam string TRACE_FILE = "tests/bus_trace.txt";

    logic  clock = 1'b0;
    logic  rst_n;
    logic  fetch_req_valid;
    logic  fetch_req_ready;
    addr_t fetch_req_addr;
    logic  fetch_rsp_valid;
    data_t fetch_rsp_data;
    logic  fetch_rsp_err;
    logic  lsu_req_valid;
    logic  lsu_req_ready;
    logic  lsu_req_write;
    addr_t lsu_req_addr;
    data_t lsu_req_wdata;
    strb_t lsu_req_wstrb;
    logic  lsu_rsp_valid;
    data_t lsu_rsp_data;
    logic  lsu_rsp_err;
    logic  mem_req_valid;
    logic  mem_req_ready;
    logic  mem_req_write;
    addr_t mem_req_addr;
    data_t mem_req_wdata;
    strb_t mem_req_wstrb;
    logic  mem_rsp_valid;
    data_t mem_rsp_data;
    logic  mem_rsp_err;
    logic  timer_irq;
    logic  soft_irq;

    string t_name [$];                                // One entry per trace line
    byte   t_req  [$];
    byte   t_op   [$];
    addr_t t_addr [$];
    data_t t_wdata[$];
    strb_t t_wstrb[$];
    data_t t_rdata[$];
    logic  t_err  [$];

    data_t       mem_words [addr_t];                  // Only written words live here
    logic [15:0] lfsr = 16'd87;
    addr_t       mem_last_addr;                       // Last request seen at the mem port
    logic        mem_last_write;
    data_t       mem_last_wdata;
    strb_t       mem_last_strb;
    int          mem_count = 0;
    data_t       prev_mtime = '0;
    data_t       cmp_lo = '0;                         // Last mtimecmp low write
    bit          loaded = 1'b0;

    cpu_bus_wrapper dut (.*);

    always #HALF clock = ~clock;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("MISMATCH %s expected %0h actual %0h", what, expected, actual));
        end
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_delay(output int d);
        d = 1;                                        // 1 to 4 cycles
        for (int i = 0; i < 2; i++) begin
            lfsr = lfsr_step(lfsr);
            d += int'(lfsr[0]) << i;
        end
    endtask

    function automatic data_t model_word(input addr_t a);
        addr_t key;
        key = {a[31:2], 2'b00};
        if (mem_words.exists(key)) begin
            return mem_words[key];
        end
        return key ^ 32'hA5A5_A5A5;                   // Untouched word
    endfunction

    task automatic quiet_outputs(input string when);
        check_value({when, " fetch_rsp_valid"}, 0, fetch_rsp_valid);
        check_value({when, " lsu_rsp_valid"}, 0, lsu_rsp_valid);
        check_value({when, " mem_req_valid"}, 0, mem_req_valid);
        check_value({when, " timer_irq"}, 0, timer_irq);
        check_value({when, " soft_irq"}, 0, soft_irq);
    endtask

    task automatic load_trace();
        int    fd;
        int    n;
        string line;
        string name;
        string req;
        string op;
        addr_t a;
        data_t wd;
        strb_t ws;
        data_t rd;
        logic  er;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            abort_run("Could not open the trace file tests/bus_trace.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") begin
                continue;                             // Blank or column notes
            end
            n = $sscanf(line, "%s %s %s %h %h %h %h %h", name, req, op, a, wd, ws, rd, er);
            if (n != 8) begin
                abort_run({"A trace line could not be parsed: ", line});
            end
            t_name.push_back(name);
            t_req.push_back(req[0]);
            t_op.push_back(op[0]);
            t_addr.push_back(a);
            t_wdata.push_back(wd);
            t_wstrb.push_back(ws);
            t_rdata.push_back(rd);
            t_err.push_back(er);
        end
        $fclose(fd);
        if (t_name.size() == 0) begin
            abort_run("The trace file holds no transactions");
        end
    endtask

    task automatic run_line(input int i);
        bit    use_f;
        bit    use_l;
        bit    is_rd;
        bit    is_wr;
        bit    clint;
        bit    f_pend;
        bit    l_pend;
        bit    f_acc;
        bit    l_acc;
        bit    f_done;
        bit    l_done;
        int    cycles;
        int    latency;
        int    count0;
        data_t f_data;
        data_t l_data;
        data_t l_exp;
        data_t got;
        string nm;
        nm    = t_name[i];
        use_f = t_req[i] == "F" || t_req[i] == "B";
        use_l = t_req[i] == "L" || t_req[i] == "B";
        is_rd = t_op[i] == "R" || t_op[i] == "M";
        is_wr = t_op[i] == "W" || t_op[i] == "S" || t_op[i] == "T";
        clint = (t_addr[i] & CLINT_MASK) == CLINT_BASE;
        if (!(use_f || use_l) || !(is_rd || is_wr) || (is_wr && t_req[i] != "L")) begin
            abort_run({"Trace line ", nm, " has an unknown requester or operation"});
        end
        l_exp  = (t_req[i] == "B") ? t_wdata[i] : t_rdata[i];  // B lines keep LSU data in wdata
        count0 = mem_count;
        if (t_op[i] == "T") begin
            check_value({nm, " timer_irq before"}, 0, timer_irq);
        end
        @(negedge clock);
        fetch_req_valid = use_f;
        fetch_req_addr  = t_addr[i];
        lsu_req_valid   = use_l;
        lsu_req_write   = is_wr;
        lsu_req_addr    = (t_req[i] == "B") ? t_addr[i] + 32'd4 : t_addr[i];
        lsu_req_wdata   = t_wdata[i];
        lsu_req_wstrb   = t_wstrb[i];
        f_pend  = use_f;
        l_pend  = use_l;
        f_done  = !use_f;
        l_done  = !use_l;
        cycles  = 0;
        latency = 0;
        while (!(f_done && l_done)) begin
            #(HALF - 1);                              // Sample mid-cycle once ready has settled
            f_acc = f_pend && fetch_req_ready;
            l_acc = l_pend && lsu_req_ready;
            @(negedge clock);
            if (f_acc || l_acc) begin
                cycles = 0;
            end
            cycles++;
            if (f_acc) begin
                fetch_req_valid = 1'b0;
                f_pend          = 1'b0;
            end
            if (l_acc) begin
                lsu_req_valid = 1'b0;
                l_pend        = 1'b0;
            end
            if (fetch_rsp_valid) begin
                if (f_done || f_pend) begin
                    abort_run({nm, ": fetch received a response it did not ask for"});
                end
                check_value({nm, " fetch err"}, t_err[i], fetch_rsp_err);
                f_data  = fetch_rsp_data;
                f_done  = 1'b1;
                latency = cycles;
            end
            if (lsu_rsp_valid) begin
                if (l_done || l_pend) begin
                    abort_run({nm, ": load/store received a response it did not ask for"});
                end
                check_value({nm, " lsu err"}, t_err[i], lsu_rsp_err);
                l_data  = lsu_rsp_data;
                l_done  = 1'b1;
                latency = cycles;
            end
        end
        if (t_op[i] == "M") begin
            got = use_f ? f_data : l_data;
            check_value({nm, " mtime increasing"}, 1, got > prev_mtime);
            prev_mtime = got;
        end else begin
            if (use_f) begin
                check_value({nm, " fetch rdata"}, t_rdata[i], f_data);
            end
            if (use_l) begin
                check_value({nm, " lsu rdata"}, l_exp, l_data);
            end
        end
        if (t_req[i] != "B" && clint) begin
            check_value({nm, " latency"}, 2, latency);
            check_value({nm, " no external access"}, count0, mem_count);
        end else if (t_req[i] != "B") begin
            check_value({nm, " mem addr"}, t_addr[i], mem_last_addr);
            check_value({nm, " mem write"}, is_wr, mem_last_write);
            if (is_wr) begin
                check_value({nm, " mem wdata"}, t_wdata[i], mem_last_wdata);
                check_value({nm, " mem wstrb"}, t_wstrb[i], mem_last_strb);
            end
        end
        if (t_op[i] == "S") begin
            for (int w = 0; w < 4 && soft_irq !== t_wdata[i][0]; w++) begin
                @(negedge clock);
            end
            check_value({nm, " soft_irq"}, t_wdata[i][0], soft_irq);
        end
        if (t_op[i] == "T") begin
            for (int w = 0; w < int'(cmp_lo) + 2 && timer_irq !== 1'b1; w++) begin
                @(negedge clock);
            end
            check_value({nm, " timer_irq"}, 1, timer_irq);
        end
        if (is_wr && t_addr[i] == CLINT_BASE + 32'(OFF_MTIMECMP_LO)) begin
            cmp_lo = t_wdata[i];
        end
    endtask

    // External memory model with random ready and response delays
    initial begin : mem_model
        int    d;
        addr_t a;
        data_t mask;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data  = '0;
        mem_rsp_err   = 1'b0;
        forever begin
            @(negedge clock);
            mem_rsp_valid = 1'b0;                     // One-cycle pulse
            if (mem_req_valid) begin
                random_delay(d);
                repeat (d - 1) @(negedge clock);
                mem_req_ready  = 1'b1;
                a              = mem_req_addr;
                mem_last_addr  = mem_req_addr;
                mem_last_write = mem_req_write;
                mem_last_wdata = mem_req_wdata;
                mem_last_strb  = mem_req_wstrb;
                mem_count++;
                @(negedge clock);
                mem_req_ready = 1'b0;
                random_delay(d);
                repeat (d - 1) @(negedge clock);
                mem_rsp_err  = a >= 32'hF000_0000;    // Faulting region
                mem_rsp_data = '0;
                mask = {{8{mem_last_strb[3]}}, {8{mem_last_strb[2]}},
                        {8{mem_last_strb[1]}}, {8{mem_last_strb[0]}}};
                if (!mem_rsp_err && mem_last_write) begin
                    mem_words[{a[31:2], 2'b00}] = (model_word(a) & ~mask)
                                                  | (mem_last_wdata & mask);
                    mem_rsp_data = model_word(a);     // Merged word echoed back
                end else if (!mem_rsp_err) begin
                    mem_rsp_data = model_word(a);
                end
                mem_rsp_valid = 1'b1;
            end
        end
    end

    initial begin : watchdog
        wait (loaded);
        repeat (t_name.size() * 40 + 200) @(posedge clock);
        abort_run("Timeout: the bus stopped answering before the trace was finished");
    end

    initial begin : main
        rst_n           = 1'b0;
        fetch_req_valid = 1'b0;
        fetch_req_addr  = '0;
        lsu_req_valid   = 1'b0;
        lsu_req_write   = 1'b0;
        lsu_req_addr    = '0;
        lsu_req_wdata   = '0;
        lsu_req_wstrb   = '0;
        load_trace();
        loaded = 1'b1;
        repeat (10) begin
            @(negedge clock);
            quiet_outputs("reset");
        end
        rst_n = 1'b1;
        @(negedge clock);
        quiet_outputs("after reset");
        foreach (t_name[i]) begin
            run_line(i);
        end
        repeat (2) @(negedge clock);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
